/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_core \
		-f cpu_core.f --Mdir obj_dir -o sim_cpu_core
	./obj_dir/sim_cpu_core > sim.log 2>&1; cat sim.log
	@grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* cpu_core.f */
+incdir+tb
verilog/cpu_pkg.sv
verilog/result_if.sv
verilog/pc_fetch.sv
verilog/decode_ctrl.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/cpu_core.sv
tb/tb_cpu_core.sv

/* tb/cpu_tests.svh */
//////////////////////////////
// Reference model
//////////////////////////////

// Steps through the loaded program in ISA order, no pipeline
function automatic logic [DATA_W-1:0] model_r3();
	logic [DATA_W-1:0]  r [16];
	logic [PC_W-1:0]    pc;
	logic [INSTR_W-1:0] ins;
	logic [3:0]         rd;
	logic [DATA_W-1:0]  imm;
	logic [DATA_W-1:0]  a;
	logic [DATA_W-1:0]  b;
	logic [DATA_W-1:0]  v;
	bit                 we;
	bit                 stop;
	int                 steps;
	foreach (r[i]) r[i] = '0;
	pc = '0;
	stop = 1'b0;
	steps = 0;
	while (!stop && steps < 64) begin
		ins = imem[pc];
		rd = ins[11:8];
		imm = {{(DATA_W - 8){ins[7]}}, ins[7:0]};
		a = r[ins[7:4]];
		b = r[ins[3:0]];
		v = '0;
		we = 1'b1;
		pc = pc + 8'd1;
		case (ins[15:12])
			OP_ADD:  v = a + b;
			OP_SUB:  v = a - b;
			OP_AND:  v = a & b;
			OP_OR:   v = a | b;
			OP_XOR:  v = a ^ b;
			OP_SHL:  v = a << b[3:0];
			OP_SHR:  v = a >> b[3:0];
			OP_ADDI: v = r[rd] + imm;
			OP_LI:   v = imm;
			OP_JAL: begin
				we = 1'b0;
				r[RA_REG] = {{(DATA_W - PC_W){1'b0}}, pc};
				pc = ins[7:0];
			end
			OP_JR: begin
				we = 1'b0;
				pc = a[PC_W-1:0];
			end
			OP_HALT: begin
				we = 1'b0;
				stop = 1'b1;
				// Pc stays on the HALT itself
				model_halt_pc = pc - 8'd1;
			end
			default: we = 1'b0;
		endcase
		// r0 stays zero, r13 only changes through JAL
		if (we && (rd != ZERO_REG) && (rd != RA_REG)) r[rd] = v;
		steps++;
	end
	return r[3];
endfunction

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic alu_test();
	logic [7:0] x;
	logic [7:0] y;
	logic [7:0] s;
	x = 8'($random(seed));
	y = 8'($random(seed));
	s = (8'($random(seed)) & 8'h0f) | 8'h01;
	start_program();
	emit(imm_instr(OP_LI, 4'd1, x));
	emit(imm_instr(OP_LI, 4'd2, y));
	emit(imm_instr(OP_LI, 4'd5, s));
	// Each result folds into r3 so a wrong op shows at the end
	emit(reg_instr(OP_ADD, 4'd3, 4'd1, 4'd2));
	emit(reg_instr(OP_SUB, 4'd4, 4'd1, 4'd2));
	emit(reg_instr(OP_XOR, 4'd3, 4'd3, 4'd4));
	emit(reg_instr(OP_AND, 4'd4, 4'd1, 4'd2));
	emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd4));
	emit(reg_instr(OP_OR, 4'd4, 4'd1, 4'd2));
	emit(reg_instr(OP_SUB, 4'd3, 4'd3, 4'd4));
	emit(reg_instr(OP_SHL, 4'd4, 4'd1, 4'd5));
	emit(reg_instr(OP_XOR, 4'd3, 4'd3, 4'd4));
	emit(reg_instr(OP_SHR, 4'd4, 4'd2, 4'd5));
	emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd4));
	emit(reg_instr(OP_HALT, 4'd0, 4'd0, 4'd0));
	run_and_check("alu_ops", model_r3());
endtask

task automatic dependency_test();
	start_program();
	emit(imm_instr(OP_LI, 4'd3, 8'($random(seed))));
	// Every ADDI needs the result of the one just before
	repeat (4) emit(imm_instr(OP_ADDI, 4'd3, 8'($random(seed))));
	emit(imm_instr(OP_LI, 4'd4, 8'($random(seed))));
	emit(imm_instr(OP_LI, 4'd5, 8'($random(seed))));
	// r4 comes from writeback, r5 from execute
	emit(reg_instr(OP_ADD, 4'd6, 4'd4, 4'd5));
	emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd6));
	emit(imm_instr(OP_ADDI, 4'd3, 8'($random(seed))));
	emit(reg_instr(OP_HALT, 4'd0, 4'd0, 4'd0));
	run_and_check("dependencies", model_r3());
endtask

task automatic zero_reg_test();
	start_program();
	emit(imm_instr(OP_LI, 4'd3, 8'($random(seed))));
	emit(imm_instr(OP_LI, 4'd0, 8'($random(seed)) | 8'h01));
	emit(imm_instr(OP_ADDI, 4'd0, 8'h10));
	// r0 read once from execute and once from writeback
	emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd0));
	emit(reg_instr(OP_ADD, 4'd3, 4'd3, 4'd0));
	emit(reg_instr(OP_HALT, 4'd0, 4'd0, 4'd0));
	run_and_check("zero_register", model_r3());
endtask

task automatic link_reg_test();
	start_program();
	repeat (3) emit(reg_instr(OP_NOP, 4'd0, 4'd0, 4'd0));
	// JAL at 3 links 4 into r13
	emit(imm_instr(OP_JAL, 4'd0, 8'd8));
	repeat (4) emit(imm_instr(OP_LI, 4'd3, 8'h7f));
	emit(imm_instr(OP_LI, RA_REG, 8'h55));
	emit(imm_instr(OP_ADDI, RA_REG, 8'h21));
	emit(reg_instr(OP_ADD, 4'd3, RA_REG, 4'd0));
	emit(reg_instr(OP_HALT, 4'd0, 4'd0, 4'd0));
	run_and_check("link_register", model_r3());
endtask

task automatic jump_halt_test();
	start_program();
	emit(imm_instr(OP_LI, 4'd3, 8'd10));
	emit(imm_instr(OP_JAL, 4'd0, 8'd6));
	emit(imm_instr(OP_ADDI, 4'd3, 8'($random(seed))));
	emit(reg_instr(OP_HALT, 4'd0, 4'd0, 4'd0));
	// Never reached, pc holds on the HALT above
	emit(imm_instr(OP_LI, 4'd3, 8'h66));
	emit(imm_instr(OP_LI, 4'd3, 8'h66));
	emit(reg_instr(OP_ADD, 4'd3, 4'd3, RA_REG));
	emit(reg_instr(OP_JR, 4'd0, RA_REG, 4'd0));
	run_and_check("jump_and_halt", model_r3());
endtask

/* tb/tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int unsigned DATA_W = 16;
	localparam int unsigned MEM_DEPTH = 256;
	localparam int unsigned TEST_COUNT = 5;
	localparam int unsigned TEST_CYCLES = 64;
	localparam int unsigned CYCLE_LIMIT = TEST_COUNT * TEST_CYCLES + 40;
	// Reset, run and hold together stay inside one test's cycle budget
	localparam int unsigned HALT_WAIT = 48;
	localparam int unsigned HOLD_CYCLES = 10;

	logic               clk;
	logic               rst;
	logic [PC_W-1:0]    instr_addr;
	logic [INSTR_W-1:0] instr_data;
	logic [DATA_W-1:0]  debug_out;
	logic               halted;

	logic [INSTR_W-1:0] imem [MEM_DEPTH];
	int                 load_addr;
	int                 seed;
	int                 cycle_count = 0;
	int                 test_errors;
	int                 total_errors = 0;
	int                 pass_tests = 0;
	int                 fail_tests = 0;
	// HALT address found by the reference model
	logic [PC_W-1:0]    model_halt_pc;

	cpu_core #(.DATA_W(DATA_W)) dut0 (
		.clk        (clk),
		.rst        (rst),
		.instr_addr (instr_addr),
		.instr_data (instr_data),
		.debug_out  (debug_out),
		.halted     (halted)
	);

	//////////////////////////////
	// Clock and run limit
	//////////////////////////////

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped at %0d ns, cycle limit of %0d reached", $time, CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Instruction memory model
	//////////////////////////////

	assign instr_data = imem[instr_addr];

	// Unused words are HALTs tagged with their own address
	task automatic start_program();
		for (int i = 0; i < MEM_DEPTH; i++) begin
			imem[i] = {OP_HALT, i[7:0], 4'h0};
		end
		load_addr = 0;
	endtask

	task automatic emit(input logic [INSTR_W-1:0] word);
		imem[load_addr] = word;
		load_addr++;
	endtask

	function automatic logic [INSTR_W-1:0] reg_instr(input opcode_e op, input logic [3:0] rd,
			input logic [3:0] rs1, input logic [3:0] rs2);
		return {op, rd, rs1, rs2};
	endfunction

	function automatic logic [INSTR_W-1:0] imm_instr(input opcode_e op, input logic [3:0] rd,
			input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	//////////////////////////////
	// Run and check
	//////////////////////////////

	task automatic apply_reset();
		@(posedge clk);
		#1 rst = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	task automatic wait_for_halt(output bit done);
		int waited;
		waited = 0;
		done = 1'b0;
		while (!done && waited < HALT_WAIT) begin
			@(posedge clk);
			#1;
			waited++;
			done = halted;
		end
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] expected);
		if (got !== expected) begin
			$display("FAIL %0d ns: %s = %h, expected %h", $time, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic run_and_check(input string name, input logic [DATA_W-1:0] expected);
		bit done;
		test_errors = 0;
		apply_reset();
		wait_for_halt(done);
		if (!done) begin
			$display("%0d ns: %s did not halt within %0d cycles", $time, name, HALT_WAIT);
			test_errors++;
		end else begin
			check_value("debug_out", debug_out, expected);
			check_value("instr_addr", instr_addr, model_halt_pc);
			// Core must stay stopped with r3 frozen and pc on the HALT
			repeat (HOLD_CYCLES) begin
				@(posedge clk);
				#1;
				if (!halted) begin
					$display("%0d ns: %s halted dropped before reset", $time, name);
					test_errors++;
				end
				check_value("debug_out", debug_out, expected);
				check_value("instr_addr", instr_addr, model_halt_pc);
			end
		end
		total_errors += test_errors;
		if (test_errors == 0) begin
			pass_tests++;
			$display("test %s: passed", name);
		end else begin
			fail_tests++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
	endtask

	`include "cpu_tests.svh"

	initial begin
		rst = 1'b1;
		seed = 27576;
		start_program();
		alu_test();
		dependency_test();
		zero_reg_test();
		link_reg_test();
		jump_halt_test();
		$display("Tests passed %0d, failed %0d, failed checks %0d",
			pass_tests, fail_tests, total_errors);
		if (fail_tests == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core #(
	parameter int unsigned DATA_W = 16
) (
	input  logic                        clk,
	input  logic                        rst,
	output logic [cpu_pkg::PC_W-1:0]    instr_addr,
	input  logic [cpu_pkg::INSTR_W-1:0] instr_data,
	output logic [DATA_W-1:0]           debug_out,
	output logic                        halted
);
	import cpu_pkg::*;

	// Decode to fetch
	logic                  jump_en;
	logic [PC_W-1:0]       jump_target;
	logic                  hold;

	// Decode to register file
	logic [REG_ADDR_W-1:0] read_addr1;
	logic [REG_ADDR_W-1:0] read_addr2;
	logic [DATA_W-1:0]     read_value1;
	logic [DATA_W-1:0]     read_value2;
	logic                  ra_we;
	logic [DATA_W-1:0]     ra_value;

	// Execute stage
	logic                  ex_valid;
	alu_op_e               ex_op;
	logic [DATA_W-1:0]     ex_a;
	logic [DATA_W-1:0]     ex_b;
	logic [REG_ADDR_W-1:0] ex_rd;

	result_if #(.DATA_W(DATA_W)) res_bus ();

	// Pc goes straight out as the instruction address
	pc_fetch pc0 (
		.clk         (clk),
		.rst         (rst),
		.jump_en     (jump_en),
		.jump_target (jump_target),
		.hold        (hold),
		.pc          (instr_addr)
	);

	decode_ctrl #(.DATA_W(DATA_W)) dec0 (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr_data),
		.pc          (instr_addr),
		.rs1_value   (read_value1),
		.rs2_value   (read_value2),
		.read_addr1  (read_addr1),
		.read_addr2  (read_addr2),
		.ex_valid    (ex_valid),
		.ex_op       (ex_op),
		.ex_a        (ex_a),
		.ex_b        (ex_b),
		.ex_rd       (ex_rd),
		.jump_en     (jump_en),
		.jump_target (jump_target),
		.hold        (hold),
		.ra_we       (ra_we),
		.ra_value    (ra_value),
		.halted      (halted)
	);

	reg_file #(.DATA_W(DATA_W)) regs0 (
		.clk         (clk),
		.rst         (rst),
		.res         (res_bus.regs),
		.read_addr1  (read_addr1),
		.read_value1 (read_value1),
		.read_addr2  (read_addr2),
		.read_value2 (read_value2),
		.ra_we       (ra_we),
		.ra_value    (ra_value),
		.debug_out   (debug_out)
	);

	exec_unit #(.DATA_W(DATA_W)) exec0 (
		.clk      (clk),
		.rst      (rst),
		.ex_valid (ex_valid),
		.ex_op    (ex_op),
		.ex_a     (ex_a),
		.ex_b     (ex_b),
		.ex_rd    (ex_rd),
		.res      (res_bus.exec)
	);

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

	//////////////////////////////
	// Instruction format
	//////////////////////////////

	localparam int unsigned INSTR_W = 16;
	localparam int unsigned PC_W = 8;

	// Field positions
	localparam int unsigned OPC_MSB = 15;
	localparam int unsigned OPC_LSB = 12;
	localparam int unsigned RD_MSB = 11;
	localparam int unsigned RD_LSB = 8;
	localparam int unsigned RS1_MSB = 7;
	localparam int unsigned RS1_LSB = 4;
	localparam int unsigned RS2_MSB = 3;
	localparam int unsigned RS2_LSB = 0;
	localparam int unsigned IMM_MSB = 7;
	localparam int unsigned IMM_LSB = 0;

	// Register file
	localparam int unsigned REG_ADDR_W = 4;
	localparam int unsigned NUM_REGS = 2 ** REG_ADDR_W;
	localparam logic [REG_ADDR_W-1:0] ZERO_REG = 4'd0;
	localparam logic [REG_ADDR_W-1:0] RA_REG = 4'd13;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SHL  = 4'h6,
		OP_SHR  = 4'h7,
		OP_ADDI = 4'h8,
		OP_LI   = 4'h9,
		OP_JAL  = 4'hA,
		OP_JR   = 4'hB,
		OP_HALT = 4'hF
	} opcode_e;

	// Operation handed from decode to execute
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_SHL    = 3'd5,
		ALU_SHR    = 3'd6,
		ALU_PASS_B = 3'd7
	} alu_op_e;

endpackage

/* verilog/decode_ctrl.sv */
`timescale 1ns/100ps

module decode_ctrl #(
	parameter int unsigned DATA_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [cpu_pkg::INSTR_W-1:0]    instr,
	input  logic [cpu_pkg::PC_W-1:0]       pc,
	input  logic [DATA_W-1:0]              rs1_value,
	input  logic [DATA_W-1:0]              rs2_value,
	output logic [cpu_pkg::REG_ADDR_W-1:0] read_addr1,
	output logic [cpu_pkg::REG_ADDR_W-1:0] read_addr2,
	output logic                           ex_valid,
	output cpu_pkg::alu_op_e               ex_op,
	output logic [DATA_W-1:0]              ex_a,
	output logic [DATA_W-1:0]              ex_b,
	output logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd,
	output logic                           jump_en,
	output logic [cpu_pkg::PC_W-1:0]       jump_target,
	output logic                           hold,
	output logic                           ra_we,
	output logic [DATA_W-1:0]              ra_value,
	output logic                           halted
);
	import cpu_pkg::*;

	localparam int unsigned IMM_W = IMM_MSB - IMM_LSB + 1;

	typedef enum logic [1:0] {
		ST_RUN,
		ST_DRAIN,
		ST_STOP
	} halt_state_e;

	halt_state_e           state;
	opcode_e               opcode;
	logic [REG_ADDR_W-1:0] rd;
	logic [IMM_W-1:0]      imm8;
	logic [DATA_W-1:0]     imm_ext;
	logic [PC_W-1:0]       link_pc;
	logic                  issue;
	logic                  halt_dec;
	alu_op_e               op_sel;
	logic [DATA_W-1:0]     a_sel;
	logic [DATA_W-1:0]     b_sel;

	//////////////////////////////
	// Field extraction
	//////////////////////////////

	assign opcode = opcode_e'(instr[OPC_MSB:OPC_LSB]);
	assign rd = instr[RD_MSB:RD_LSB];
	assign imm8 = instr[IMM_MSB:IMM_LSB];
	assign imm_ext = {{(DATA_W - IMM_W){imm8[IMM_W-1]}}, imm8};

	// ADDI uses rd as its source, rs1 bits belong to the immediate
	assign read_addr1 = (opcode == OP_ADDI) ? rd : instr[RS1_MSB:RS1_LSB];
	assign read_addr2 = instr[RS2_MSB:RS2_LSB];

	// Link value is the address after the JAL
	assign link_pc = pc + 1'b1;
	assign ra_value = {{(DATA_W - PC_W){1'b0}}, link_pc};

	always_comb begin
		issue = 1'b0;
		halt_dec = 1'b0;
		op_sel = ALU_ADD;
		a_sel = rs1_value;
		b_sel = rs2_value;
		jump_en = 1'b0;
		jump_target = imm8;
		ra_we = 1'b0;
		if (state == ST_RUN) begin
			case (opcode)
				OP_ADD: begin issue = 1'b1; op_sel = ALU_ADD; end
				OP_SUB: begin issue = 1'b1; op_sel = ALU_SUB; end
				OP_AND: begin issue = 1'b1; op_sel = ALU_AND; end
				OP_OR:  begin issue = 1'b1; op_sel = ALU_OR;  end
				OP_XOR: begin issue = 1'b1; op_sel = ALU_XOR; end
				OP_SHL: begin issue = 1'b1; op_sel = ALU_SHL; end
				OP_SHR: begin issue = 1'b1; op_sel = ALU_SHR; end
				OP_ADDI: begin
					issue = 1'b1;
					b_sel = imm_ext;
				end
				OP_LI: begin
					issue = 1'b1;
					op_sel = ALU_PASS_B;
					a_sel = '0;
					b_sel = imm_ext;
				end
				OP_JAL: begin
					jump_en = 1'b1;
					ra_we = 1'b1;
				end
				OP_JR: begin
					jump_en = 1'b1;
					jump_target = rs1_value[PC_W-1:0];
				end
				OP_HALT: halt_dec = 1'b1;
				default: ;
			endcase
		end
	end

	// Pc stays on HALT from the decode cycle onwards
	assign hold = halt_dec || (state != ST_RUN);

	//////////////////////////////
	// Execute stage register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		ex_op <= op_sel;
		ex_a <= a_sel;
		ex_b <= b_sel;
		ex_rd <= rd;
	end

	//////////////////////////////
	// Halt sequencer
	//////////////////////////////

	// Drain covers the HALT decode cycle and the next one, by then the
	// last older result has been written
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_RUN;
		end else begin
			case (state)
				ST_RUN:   if (halt_dec) state <= ST_DRAIN;
				ST_DRAIN: state <= ST_STOP;
				default:  state <= ST_STOP;
			endcase
		end
	end

	assign halted = (state == ST_STOP);

	no_issue_after_halt: assert property (
		@(posedge clk) disable iff (rst)
		halted |-> !ex_valid
	) else $error("instruction reached execute after halt");

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit #(
	parameter int unsigned DATA_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           ex_valid,
	input  cpu_pkg::alu_op_e               ex_op,
	input  logic [DATA_W-1:0]              ex_a,
	input  logic [DATA_W-1:0]              ex_b,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd,
	result_if.exec                         res
);
	import cpu_pkg::*;

	logic              result_we;
	logic [DATA_W-1:0] result;
	logic [3:0]        shamt;

	assign shamt = ex_b[3:0];

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (ex_op)
			ALU_ADD:    result = ex_a + ex_b;
			ALU_SUB:    result = ex_a - ex_b;
			ALU_AND:    result = ex_a & ex_b;
			ALU_OR:     result = ex_a | ex_b;
			ALU_XOR:    result = ex_a ^ ex_b;
			ALU_SHL:    result = ex_a << shamt;
			ALU_SHR:    result = ex_a >> shamt;
			ALU_PASS_B: result = ex_b;
			default:    result = '0;
		endcase
	end

	// Results for r0 and r13 never leave execute
	assign result_we = ex_valid && (ex_rd != ZERO_REG) && (ex_rd != RA_REG);

	assign res.alu_we = result_we;
	assign res.alu_addr = ex_rd;
	assign res.alu_value = result;

	//////////////////////////////
	// Writeback register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			res.wr_we <= 1'b0;
		end else begin
			res.wr_we <= result_we;
		end
	end

	always_ff @(posedge clk) begin
		res.wr_addr <= ex_rd;
		res.wr_value <= result;
	end

endmodule

/* verilog/pc_fetch.sv */
`timescale 1ns/100ps

module pc_fetch (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     jump_en,
	input  logic [cpu_pkg::PC_W-1:0] jump_target,
	input  logic                     hold,
	output logic [cpu_pkg::PC_W-1:0] pc
);
	import cpu_pkg::*;

	logic [PC_W-1:0] pc_inc;

	assign pc_inc = pc + 1'b1;

	//////////////////////////////
	// Program counter
	//////////////////////////////

	// Jump wins, the instruction after a jump is never fetched
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (jump_en) begin
			pc <= jump_target;
		end else if (!hold) begin
			pc <= pc_inc;
		end
	end

	// Decode never jumps while it is holding for a halt
	jump_hold_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(jump_en && hold)
	) else $error("jump_en and hold high together at pc %0d", pc);

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
	parameter int unsigned DATA_W = 16
) (
	input  logic                           clk,
	input  logic                           rst,
	result_if.regs                         res,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] read_addr1,
	output logic [DATA_W-1:0]              read_value1,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] read_addr2,
	output logic [DATA_W-1:0]              read_value2,
	input  logic                           ra_we,
	input  logic [DATA_W-1:0]              ra_value,
	output logic [DATA_W-1:0]              debug_out
);
	import cpu_pkg::*;

	localparam logic [REG_ADDR_W-1:0] DEBUG_REG = 4'd3;

	logic [DATA_W-1:0] regs [NUM_REGS];

	//////////////////////////////
	// Write ports
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Zero and link registers ignore the normal write port
			if (res.wr_we && (res.wr_addr != ZERO_REG) && (res.wr_addr != RA_REG)) begin
				regs[res.wr_addr] <= res.wr_value;
			end
			if (ra_we) begin
				regs[RA_REG] <= ra_value;
			end
		end
	end

	//////////////////////////////
	// Forwarding read ports
	//////////////////////////////

	// Youngest result first, then writeback, then the array
	function automatic logic [DATA_W-1:0] fwd_read(input logic [REG_ADDR_W-1:0] addr);
		logic [DATA_W-1:0] value;
		if (addr == ZERO_REG) begin
			value = '0;
		end else if (addr == RA_REG) begin
			value = regs[RA_REG];
		end else if (res.alu_we && (res.alu_addr == addr)) begin
			value = res.alu_value;
		end else if (res.wr_we && (res.wr_addr == addr)) begin
			value = res.wr_value;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		read_value1 = fwd_read(read_addr1);
		read_value2 = fwd_read(read_addr2);
	end

	assign debug_out = regs[DEBUG_REG];

	// Execute must filter link writes before they reach writeback
	no_wb_to_ra: assert property (
		@(posedge clk) disable iff (rst)
		!(res.wr_we && (res.wr_addr == RA_REG))
	) else $error("writeback targets the link register");

endmodule

/* verilog/result_if.sv */
`timescale 1ns/100ps

interface result_if #(
	parameter int unsigned DATA_W = 16
);
	import cpu_pkg::*;

	// Result of the instruction in execute, combinational
	logic                  alu_we;
	logic [REG_ADDR_W-1:0] alu_addr;
	logic [DATA_W-1:0]     alu_value;

	// Registered writeback, lands in the array at the next edge
	logic                  wr_we;
	logic [REG_ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0]     wr_value;

	modport exec (
		output alu_we,
		output alu_addr,
		output alu_value,
		output wr_we,
		output wr_addr,
		output wr_value
	);

	modport regs (
		input alu_we,
		input alu_addr,
		input alu_value,
		input wr_we,
		input wr_addr,
		input wr_value
	);

endinterface
